// ==== rtl/gmii_tx_pkg.sv ====
package gmii_tx_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;       // gmii / fifo byte
    typedef logic [15:0] ptr_word_t;   // pointer fifo word, low 12 bits used
    typedef logic [11:0] frame_len_t;  // payload length in bytes
    typedef logic [31:0] crc_t;
    typedef logic [19:0] mgnt_word_t;  // {flag nibble, length}

    //////////////////////////////////////////////////
    // framing
    //////////////////////////////////////////////////

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;
    localparam int    PREAMBLE_LEN  = 8;   // sfd included
    localparam int    FCS_LEN       = 4;
    localparam int    IFG_CYCLES    = 12;  // minimum idle between frames

    // normal (non reflected) form of the 802.3 polynomial
    localparam crc_t CRC_POLY = 32'h04C1_1DB7;
    localparam crc_t CRC_INIT = 32'hFFFF_FFFF;

    localparam int MGNT_FLAG_TTE = 19;  // scheduled queue flag in report

    //////////////////////////////////////////////////
    // state machines
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ARB_IDLE,       // wait for a pointer
        ARB_PTR_READ,   // pointer read in flight
        ARB_DATA,       // one data read per cycle
        ARB_WAIT_DONE   // frame still on the wire
    } arb_state_t;

    typedef enum logic [1:0] {
        SND_IDLE,   // preamble loaded, wait for first byte
        SND_SEND,   // preamble + payload through the shift register
        SND_FCS,    // four crc bytes
        SND_GAP     // interframe gap
    } send_state_t;

endpackage

// ==== rtl/tx_byte_if.sv ====
`timescale 1ns/100ps

interface tx_byte_if;

    logic                valid;  // one strobe per byte, no back-pressure
    gmii_tx_pkg::byte_t  data;
    logic                last;   // with the final payload byte
    logic                done;   // end of interframe gap

    modport arbiter (
        output valid,
        output data,
        output last,
        input  done
    );

    modport sender (
        input  valid,
        input  data,
        input  last,
        output done
    );

endinterface

// ==== rtl/crc32_8023.sv ====
`timescale 1ns/100ps

module crc32_8023 (
    input  logic               tx_master_clk,
    input  logic               rstn_mac,
    input  logic               init,
    input  logic               calc,      // 1: fold data, 0: shift out fcs
    input  logic               d_valid,
    input  gmii_tx_pkg::byte_t d,
    output gmii_tx_pkg::byte_t fcs_byte
);

    gmii_tx_pkg::crc_t  crc_q;     // reflected register, lsb first
    gmii_tx_pkg::crc_t  crc_next;

    // bit serial fold of one byte, lsb of the byte first
    always_comb begin
        gmii_tx_pkg::crc_t poly_ref;
        poly_ref = {<<{gmii_tx_pkg::CRC_POLY}};
        crc_next = crc_q;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ d[i]) begin
                crc_next = (crc_next >> 1) ^ poly_ref;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            crc_q <= gmii_tx_pkg::CRC_INIT;
        end else if (init) begin
            crc_q <= gmii_tx_pkg::CRC_INIT;
        end else if (d_valid) begin
            if (calc) begin
                crc_q <= crc_next;
            end else begin
                crc_q <= {8'hFF, crc_q[31:8]};   // next fcs byte down
            end
        end
    end

    assign fcs_byte = ~crc_q[7:0];  // final complement

endmodule

// ==== rtl/tx_queue_arbiter.sv ====
`timescale 1ns/100ps

module tx_queue_arbiter (
    input  logic                    tx_master_clk,
    input  logic                    rstn_mac,
    input  gmii_tx_pkg::ptr_word_t  ptr_fifo_din,
    input  gmii_tx_pkg::ptr_word_t  tptr_fifo_din,
    input  logic                    ptr_fifo_empty,
    input  logic                    tptr_fifo_empty,
    input  gmii_tx_pkg::byte_t      data_fifo_din,
    input  gmii_tx_pkg::byte_t      tdata_fifo_din,
    output logic                    ptr_fifo_rd,
    output logic                    tptr_fifo_rd,
    output logic                    data_fifo_rd,
    output logic                    tdata_fifo_rd,
    output logic                    frame_start,
    output logic                    is_tte,
    output gmii_tx_pkg::frame_len_t frame_len,
    tx_byte_if.arbiter              bytes
);

    gmii_tx_pkg::arb_state_t  state;
    gmii_tx_pkg::frame_len_t  byte_cnt;   // data reads still to issue
    gmii_tx_pkg::frame_len_t  ptr_len;
    logic                     rd_active;
    logic                     rd_final;

    // pointer word of the selected queue, valid the cycle after the read
    assign ptr_len   = is_tte ? tptr_fifo_din[11:0] : ptr_fifo_din[11:0];

    assign rd_active = (state == gmii_tx_pkg::ARB_DATA);
    assign rd_final  = rd_active && (byte_cnt == gmii_tx_pkg::frame_len_t'(1));

    assign data_fifo_rd  = rd_active && !is_tte;
    assign tdata_fifo_rd = rd_active && is_tte;

    //////////////////////////////////////////////////
    // queue choice and read sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state        <= gmii_tx_pkg::ARB_IDLE;
            ptr_fifo_rd  <= 1'b0;
            tptr_fifo_rd <= 1'b0;
            is_tte       <= 1'b0;
            byte_cnt     <= '0;
            frame_start  <= 1'b0;
        end else begin
            ptr_fifo_rd  <= 1'b0;   // pointer reads are single pulses
            tptr_fifo_rd <= 1'b0;
            frame_start  <= 1'b0;
            case (state)
                gmii_tx_pkg::ARB_IDLE: begin
                    if (!tptr_fifo_empty || !ptr_fifo_empty) begin
                        // scheduled queue wins when both are waiting
                        is_tte       <= !tptr_fifo_empty;
                        tptr_fifo_rd <= !tptr_fifo_empty;
                        ptr_fifo_rd  <= tptr_fifo_empty;
                        state        <= gmii_tx_pkg::ARB_PTR_READ;
                    end
                end
                gmii_tx_pkg::ARB_PTR_READ: begin
                    // second cycle here, pointer word now on din
                    if (!ptr_fifo_rd && !tptr_fifo_rd) begin
                        if (ptr_len == '0) begin
                            state <= gmii_tx_pkg::ARB_IDLE;  // empty descriptor
                        end else begin
                            byte_cnt    <= ptr_len;
                            frame_start <= 1'b1;
                            state       <= gmii_tx_pkg::ARB_DATA;
                        end
                    end
                end
                gmii_tx_pkg::ARB_DATA: begin
                    byte_cnt <= byte_cnt - 1'b1;
                    if (rd_final) begin
                        state <= gmii_tx_pkg::ARB_WAIT_DONE;
                    end
                end
                gmii_tx_pkg::ARB_WAIT_DONE: begin
                    if (bytes.done) begin
                        state <= gmii_tx_pkg::ARB_IDLE;
                    end
                end
                default: state <= gmii_tx_pkg::ARB_IDLE;
            endcase
        end
    end

    // length for the management report, last written on the din cycle
    always_ff @(posedge tx_master_clk) begin
        if (state == gmii_tx_pkg::ARB_PTR_READ) begin
            frame_len <= ptr_len;
        end
    end

    //////////////////////////////////////////////////
    // byte stream, one cycle behind the read
    //////////////////////////////////////////////////

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            bytes.valid <= 1'b0;
            bytes.last  <= 1'b0;
        end else begin
            bytes.valid <= rd_active;
            bytes.last  <= rd_final;
        end
    end

    assign bytes.data = is_tte ? tdata_fifo_din : data_fifo_din;  // fifo output is registered

endmodule

// ==== rtl/tx_frame_sender.sv ====
`timescale 1ns/100ps

module tx_frame_sender (
    input  logic               tx_master_clk,
    input  logic               rstn_mac,
    tx_byte_if.sender          bytes,
    output gmii_tx_pkg::byte_t gtx_d,
    output logic               gtx_dv
);

    gmii_tx_pkg::send_state_t  state;

    // byte 0 leaves first, sfd sits at the top
    logic [gmii_tx_pkg::PREAMBLE_LEN*8-1:0]  shreg;
    logic [gmii_tx_pkg::PREAMBLE_LEN*8-1:0]  preamble_init;

    logic [3:0]          pre_cnt;    // bytes shifted out, saturates at preamble length
    logic [3:0]          cnt;        // flush / fcs / gap counter
    logic                flush;      // last byte seen, draining the register
    logic                shift;
    logic                payload_out;
    gmii_tx_pkg::byte_t  shift_in;
    gmii_tx_pkg::byte_t  fcs_byte;

    assign preamble_init = {gmii_tx_pkg::SFD_BYTE,
                            {(gmii_tx_pkg::PREAMBLE_LEN-1){gmii_tx_pkg::PREAMBLE_BYTE}}};

    assign shift       = bytes.valid || flush;
    assign shift_in    = bytes.valid ? bytes.data : '0;
    assign payload_out = shift && (pre_cnt == 4'(gmii_tx_pkg::PREAMBLE_LEN));

    assign bytes.done  = (state == gmii_tx_pkg::SND_GAP) &&
                         (cnt == 4'(gmii_tx_pkg::IFG_CYCLES));

    //////////////////////////////////////////////////
    // fcs over the payload as it leaves the register
    //////////////////////////////////////////////////

    crc32_8023 i_crc (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .init          (state == gmii_tx_pkg::SND_IDLE),
        .calc          (state != gmii_tx_pkg::SND_FCS),
        .d_valid       (payload_out || (state == gmii_tx_pkg::SND_FCS)),
        .d             (shreg[7:0]),
        .fcs_byte      (fcs_byte)
    );

    //////////////////////////////////////////////////
    // output sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state   <= gmii_tx_pkg::SND_IDLE;
            shreg   <= preamble_init;
            gtx_d   <= '0;
            gtx_dv  <= 1'b0;
            pre_cnt <= '0;
            cnt     <= '0;
            flush   <= 1'b0;
        end else begin
            if (shift) begin
                shreg <= {shift_in, shreg[gmii_tx_pkg::PREAMBLE_LEN*8-1:8]};
                gtx_d <= shreg[7:0];
                if (pre_cnt != 4'(gmii_tx_pkg::PREAMBLE_LEN)) begin
                    pre_cnt <= pre_cnt + 1'b1;
                end
            end
            case (state)
                gmii_tx_pkg::SND_IDLE: begin
                    if (bytes.valid) begin
                        gtx_dv <= 1'b1;
                        flush  <= bytes.last;   // one byte frame
                        cnt    <= '0;
                        state  <= gmii_tx_pkg::SND_SEND;
                    end
                end
                gmii_tx_pkg::SND_SEND: begin
                    if (bytes.valid && bytes.last) begin
                        flush <= 1'b1;
                    end
                    if (flush) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == 4'(gmii_tx_pkg::PREAMBLE_LEN-1)) begin  // register empty
                            flush <= 1'b0;
                            cnt   <= '0;
                            state <= gmii_tx_pkg::SND_FCS;
                        end
                    end
                end
                gmii_tx_pkg::SND_FCS: begin
                    gtx_d <= fcs_byte;
                    cnt   <= cnt + 1'b1;
                    if (cnt == 4'(gmii_tx_pkg::FCS_LEN-1)) begin
                        cnt   <= '0;
                        state <= gmii_tx_pkg::SND_GAP;
                    end
                end
                gmii_tx_pkg::SND_GAP: begin
                    gtx_dv <= 1'b0;     // last fcs byte still out on the first gap cycle
                    cnt    <= cnt + 1'b1;
                    if (bytes.done) begin
                        shreg   <= preamble_init;   // ready for the next frame
                        pre_cnt <= '0;
                        cnt     <= '0;
                        state   <= gmii_tx_pkg::SND_IDLE;
                    end
                end
                default: state <= gmii_tx_pkg::SND_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/tx_mgnt_report.sv ====
`timescale 1ns/100ps

module tx_mgnt_report (
    input  logic                    tx_master_clk,
    input  logic                    rstn_mac,
    input  logic                    frame_start,
    input  logic                    is_tte,
    input  gmii_tx_pkg::frame_len_t frame_len,
    input  logic                    tx_mgnt_resp,
    output logic                    tx_mgnt_valid,
    output gmii_tx_pkg::mgnt_word_t tx_mgnt_data
);

    gmii_tx_pkg::mgnt_word_t  report_word;
    logic                     capture;

    // flag nibble above the length, only the tte bit is ever set
    always_comb begin
        report_word = '0;
        report_word[gmii_tx_pkg::MGNT_FLAG_TTE] = is_tte;
        report_word[$bits(gmii_tx_pkg::frame_len_t)-1:0] = frame_len;
    end

    assign capture = frame_start && !tx_mgnt_valid;   // busy report drops the frame

    // valid doubles as the idle / report state
    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            tx_mgnt_valid <= 1'b0;
        end else if (capture) begin
            tx_mgnt_valid <= 1'b1;
        end else if (tx_mgnt_resp) begin
            tx_mgnt_valid <= 1'b0;
        end
    end

    // held unchanged while a report is pending
    always_ff @(posedge tx_master_clk) begin
        if (capture) begin
            tx_mgnt_data <= report_word;
        end
    end

endmodule

// ==== rtl/gmii_tx_mac.sv ====
`timescale 1ns/100ps

module gmii_tx_mac (
    input  logic                    tx_master_clk,
    input  logic                    rstn_mac,

    // best-effort queue
    input  gmii_tx_pkg::byte_t      data_fifo_din,    // registered fifo output
    input  logic                    data_fifo_empty,  // not needed, pointer follows data
    output logic                    data_fifo_rd,
    input  gmii_tx_pkg::ptr_word_t  ptr_fifo_din,
    input  logic                    ptr_fifo_empty,
    output logic                    ptr_fifo_rd,

    // scheduled queue
    input  gmii_tx_pkg::byte_t      tdata_fifo_din,
    input  logic                    tdata_fifo_empty, // not needed either
    output logic                    tdata_fifo_rd,
    input  gmii_tx_pkg::ptr_word_t  tptr_fifo_din,
    input  logic                    tptr_fifo_empty,
    output logic                    tptr_fifo_rd,

    // gmii
    output logic                    gtx_dv,
    output gmii_tx_pkg::byte_t      gtx_d,

    // management
    output logic                    tx_mgnt_valid,
    output gmii_tx_pkg::mgnt_word_t tx_mgnt_data,
    input  logic                    tx_mgnt_resp
);

    tx_byte_if bytes ();

    logic                     frame_start;
    logic                     is_tte;
    gmii_tx_pkg::frame_len_t  frame_len;

    tx_queue_arbiter i_arbiter (
        .tx_master_clk   (tx_master_clk),
        .rstn_mac        (rstn_mac),
        .ptr_fifo_din    (ptr_fifo_din),
        .tptr_fifo_din   (tptr_fifo_din),
        .ptr_fifo_empty  (ptr_fifo_empty),
        .tptr_fifo_empty (tptr_fifo_empty),
        .data_fifo_din   (data_fifo_din),
        .tdata_fifo_din  (tdata_fifo_din),
        .ptr_fifo_rd     (ptr_fifo_rd),
        .tptr_fifo_rd    (tptr_fifo_rd),
        .data_fifo_rd    (data_fifo_rd),
        .tdata_fifo_rd   (tdata_fifo_rd),
        .frame_start     (frame_start),
        .is_tte          (is_tte),
        .frame_len       (frame_len),
        .bytes           (bytes.arbiter)
    );

    tx_frame_sender i_sender (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .bytes         (bytes.sender),
        .gtx_d         (gtx_d),
        .gtx_dv        (gtx_dv)
    );

    tx_mgnt_report i_mgnt (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .frame_start   (frame_start),
        .is_tte        (is_tte),
        .frame_len     (frame_len),
        .tx_mgnt_resp  (tx_mgnt_resp),
        .tx_mgnt_valid (tx_mgnt_valid),
        .tx_mgnt_data  (tx_mgnt_data)
    );

endmodule

// ==== bench/tb_gmii_tx_assertions.sv ====
`timescale 1ns/100ps

module tb_gmii_tx_assertions (
    input logic                    tx_master_clk,
    input logic                    rstn_mac,
    input logic                    ptr_fifo_rd,
    input logic                    tptr_fifo_rd,
    input logic                    data_fifo_rd,
    input logic                    tdata_fifo_rd,
    input logic                    ptr_fifo_empty,
    input logic                    tptr_fifo_empty,
    input logic                    tx_mgnt_valid,
    input logic                    tx_mgnt_resp,
    input gmii_tx_pkg::mgnt_word_t tx_mgnt_data
);

    int unsigned fail_cnt = 0;

    ptr_pulse: assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        (ptr_fifo_rd || tptr_fifo_rd) |=> (!ptr_fifo_rd && !tptr_fifo_rd)) else begin
        $error("pointer read held for more than one cycle");
        fail_cnt++;
    end

    data_onehot: assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        !(data_fifo_rd && tdata_fifo_rd)) else begin
        $error("both data fifos read in the same cycle");
        fail_cnt++;
    end

    // only the matching pointer fifo counts
    ptr_not_empty: assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        !(ptr_fifo_rd && ptr_fifo_empty) && !(tptr_fifo_rd && tptr_fifo_empty)) else begin
        $error("pointer read from an empty fifo");
        fail_cnt++;
    end

    mgnt_hold: assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        (tx_mgnt_valid && !tx_mgnt_resp) |=> (tx_mgnt_valid && $stable(tx_mgnt_data))) else begin
        $error("management report dropped or changed before the response");
        fail_cnt++;
    end

endmodule

bind gmii_tx_mac tb_gmii_tx_assertions i_assertions (.*);

// ==== bench/tb_gmii_tx_mac.sv ====
`timescale 1ns/100ps

module tb_gmii_tx_mac;

    logic                    tx_master_clk = 1'b0;
    logic                    rstn_mac = 1'b0;
    gmii_tx_pkg::byte_t      data_fifo_din = '0;
    gmii_tx_pkg::byte_t      tdata_fifo_din = '0;
    logic                    data_fifo_empty = 1'b1;
    logic                    tdata_fifo_empty = 1'b1;
    gmii_tx_pkg::ptr_word_t  ptr_fifo_din = '0;
    gmii_tx_pkg::ptr_word_t  tptr_fifo_din = '0;
    logic                    ptr_fifo_empty = 1'b1;
    logic                    tptr_fifo_empty = 1'b1;
    logic                    tx_mgnt_resp = 1'b0;
    logic                    data_fifo_rd;
    logic                    tdata_fifo_rd;
    logic                    ptr_fifo_rd;
    logic                    tptr_fifo_rd;
    logic                    gtx_dv;
    gmii_tx_pkg::byte_t      gtx_d;
    logic                    tx_mgnt_valid;
    gmii_tx_pkg::mgnt_word_t tx_mgnt_data;

    // best effort and scheduled fifo contents
    gmii_tx_pkg::byte_t      be_data[$];
    gmii_tx_pkg::byte_t      tte_data[$];
    gmii_tx_pkg::ptr_word_t  be_ptr[$];
    gmii_tx_pkg::ptr_word_t  tte_ptr[$];

    // expected wire bytes and reports in send order
    gmii_tx_pkg::byte_t      exp_bytes[$];
    int                      exp_lens[$];      // gtx_dv high cycles per frame
    gmii_tx_pkg::mgnt_word_t exp_rpt[$];
    int                      exp_delay[$];     // response delay per report

    logic [31:0] lfsr = 32'd29;
    logic        hold = 1'b1;       // both pointer fifos look empty while set
    logic [3:0]  rd_q = '0;
    logic        in_frame = 1'b0;
    logic        rpt_busy = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          nbytes = 0;
    int          low_cnt = 0;
    int          frames_seen = 0;
    int          reports = 0;
    int          resp_wait = 0;

    gmii_tx_mac i_dut (.*);

    always #50 tx_master_clk = ~tx_master_clk;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic draw_bits(input int nbits, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v = {v[30:0], lfsr[0]};   // one step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // reflected 802.3 crc with final complement
    function automatic logic [31:0] ref_fcs(input gmii_tx_pkg::byte_t pay[$]);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        foreach (pay[i]) begin
            c = c ^ {24'h0, pay[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    task automatic add_frame(input logic tte, input int len);
        logic [31:0]            v;
        gmii_tx_pkg::ptr_word_t word;
        for (int i = 0; i < len; i++) begin
            draw_bits(8, v);
            if (tte) tte_data.push_back(v[7:0]);
            else be_data.push_back(v[7:0]);
        end
        draw_bits(4, v);
        word = {v[3:0], 12'(len)};    // junk in the unused top nibble
        if (tte) tte_ptr.push_back(word);
        else be_ptr.push_back(word);
    endtask

    task automatic queue_expected(input logic tte, input gmii_tx_pkg::ptr_word_t ptrs[$],
                                  input gmii_tx_pkg::byte_t data[$]);
        gmii_tx_pkg::byte_t pay[$];
        logic [11:0]        len;
        logic [31:0]        fcs;
        logic [31:0]        v;
        int                 off;
        off = 0;
        foreach (ptrs[f]) begin
            len = ptrs[f][11:0];
            pay.delete();
            for (int i = 0; i < len; i++) pay.push_back(data[off + i]);
            off += len;
            fcs = ref_fcs(pay);
            for (int i = 0; i < 7; i++) exp_bytes.push_back(8'h55);
            exp_bytes.push_back(8'hD5);
            foreach (pay[i]) exp_bytes.push_back(pay[i]);
            for (int k = 0; k < 4; k++) exp_bytes.push_back(fcs[8*k +: 8]);  // low byte first
            exp_lens.push_back(len + 12);
            exp_rpt.push_back({tte, 7'b0, len});
            draw_bits(2, v);
            exp_delay.push_back(v % 3 + 1);
        end
    endtask

    // scheduled frames lead and each queue keeps its own order
    task automatic release_group(input string name);
        int cycles;
        queue_expected(1'b1, tte_ptr, tte_data);
        queue_expected(1'b0, be_ptr, be_data);
        hold = 1'b0;
        cycles = 0;
        while (exp_lens.size() != 0 || in_frame || rpt_busy || tx_mgnt_valid) begin
            if (cycles == 5000) begin
                $display("%s: timed out waiting for the DUT to send its frames", name);
                $display("Test failed");
                $finish;
            end
            @(negedge tx_master_clk);
            cycles++;
        end
        hold = 1'b1;
        compare(exp_rpt.size(), 0, "reports still missing");
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    //////////////////////////////////////////////////
    // fifo models, gmii monitor, management side
    //////////////////////////////////////////////////

    always @(negedge tx_master_clk) begin
        // word shows up the cycle after the read
        if (rd_q[0]) data_fifo_din = be_data.pop_front();
        if (rd_q[1]) tdata_fifo_din = tte_data.pop_front();
        if (rd_q[2]) ptr_fifo_din = be_ptr.pop_front();
        if (rd_q[3]) tptr_fifo_din = tte_ptr.pop_front();
        rd_q = {tptr_fifo_rd, ptr_fifo_rd, tdata_fifo_rd, data_fifo_rd};
        data_fifo_empty  = (be_data.size() == 0);
        tdata_fifo_empty = (tte_data.size() == 0);
        ptr_fifo_empty   = hold || (be_ptr.size() == 0);
        tptr_fifo_empty  = hold || (tte_ptr.size() == 0);
    end

    always @(negedge tx_master_clk) begin
        if (gtx_dv) begin
            if (!in_frame) begin
                in_frame = 1'b1;
                nbytes = 0;
                if (frames_seen > 0) compare(low_cnt >= 12, 1, "interframe gap");
            end
            nbytes++;
            if (exp_bytes.size() == 0) begin
                $display("gtx_d carries a byte at %0t ns with no frame expected", $time);
                errors++;
            end else begin
                compare(gtx_d, exp_bytes.pop_front(), "gtx_d byte");
            end
        end else if (in_frame) begin
            in_frame = 1'b0;
            frames_seen++;
            low_cnt = 1;    // this cycle is the first low one
            if (exp_lens.size() != 0) compare(nbytes, exp_lens.pop_front(), "gtx_dv high cycles");
        end else begin
            low_cnt++;
        end
    end

    always @(negedge tx_master_clk) begin
        if (tx_mgnt_resp) begin
            tx_mgnt_resp = 1'b0;
        end else if (rpt_busy) begin
            resp_wait--;
            if (resp_wait == 0) begin
                tx_mgnt_resp = 1'b1;
                rpt_busy = 1'b0;
            end
        end else if (tx_mgnt_valid) begin
            reports++;
            if (exp_rpt.size() == 0) begin
                $display("management report at %0t ns with no frame behind it", $time);
                errors++;
            end else begin
                compare(tx_mgnt_data, exp_rpt.pop_front(), "management report");
                resp_wait = exp_delay.pop_front();
                rpt_busy = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] v;
        logic [31:0] sel;
        int          errs;
        repeat (10) @(negedge tx_master_clk);
        rstn_mac = 1'b1;

        errs = errors;
        repeat (20) begin
            @(negedge tx_master_clk);
            compare({data_fifo_rd, tdata_fifo_rd, ptr_fifo_rd, tptr_fifo_rd, gtx_dv,
                     tx_mgnt_valid}, 0, "outputs idle after reset");
        end
        end_test("reset", errs);

        errs = errors;
        draw_bits(6, v);
        add_frame(1'b0, v + 1);
        release_group("single frame");
        end_test("single frame", errs);

        // best effort loaded first
        errs = errors;
        for (int i = 0; i < 4; i++) begin
            draw_bits(6, v);
            add_frame(i >= 2, v + 1);
        end
        release_group("queue priority");
        end_test("queue priority", errs);

        errs = errors;
        for (int i = 0; i < 40; i++) begin
            draw_bits(1, sel);
            draw_bits(6, v);
            add_frame(sel[0], v + 1);
            if (i % 4 == 3) release_group("random run");
        end
        end_test("random run", errs);

        compare(reports, frames_seen, "one report per frame");
        $display("summary: %0d tests, %0d failed, %0d frames, %0d checks, %0d errors",
                 tests_run, tests_failed, frames_seen, checks, errors);
        if (errors == 0 && i_dut.i_assertions.fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
rtl/gmii_tx_pkg.sv
rtl/tx_byte_if.sv
rtl/crc32_8023.sv
rtl/tx_queue_arbiter.sv
rtl/tx_frame_sender.sv
rtl/tx_mgnt_report.sv
rtl/gmii_tx_mac.sv
bench/tb_gmii_tx_assertions.sv
bench/tb_gmii_tx_mac.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_gmii_tx_mac \
    -f files.f -o tb_gmii_tx_mac || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/tb_gmii_tx_mac)
echo "$out"
echo "$out" | grep -qx "Test completed successfully" && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }
